//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_delay_line
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard hw/*.sv hw/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/delay_config.sv
`default_nettype none
`timescale 1ns/1ps

`include "delay_consts.svh"

module delay_config import delay_ctrl_pkg::*; (
  input  wire         CLK,
  input  wire         RESETN,
  input  wire delay_t delay,
  input  wire         delay_load,
  output delay_t      cur_delay,
  output wire         flush
);

  localparam int WAIT_W = $clog2(`RST_BUSY_CYCLES + 1);

  cfg_state_t        state;
  logic [WAIT_W-1:0] wait_cnt;

  assign flush = (state == FLUSH);

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state     <= RUN;
      cur_delay <= delay;  // follows the port while in reset.
      wait_cnt  <= '0;
    end else begin
      case (state)
        RUN: begin
          if (delay_load && (delay != cur_delay)) begin
            cur_delay <= delay;
            state     <= FLUSH;
          end
        end
        FLUSH: begin
          wait_cnt <= WAIT_W'(`RST_BUSY_CYCLES);
          state    <= WAIT_BUSY;
        end
        WAIT_BUSY: begin
          wait_cnt <= wait_cnt - 1'b1;
          if (wait_cnt == WAIT_W'(1)) begin
            state <= RUN;  // FIFO busy window is over.
          end
        end
        default: state <= RUN;
      endcase
    end
  end

  a_flush_single: assert property (@(posedge CLK) disable iff (!RESETN) flush |=> !flush)
    else $error("delay_config: flush held for two cycles");

endmodule

`default_nettype wire

//--- hw/delay_consts.svh
`ifndef DELAY_CONSTS_SVH
`define DELAY_CONSTS_SVH

// width of one stream sample.
`define SAMPLE_WIDTH 16

// width of a delay value, so the longest delay is 127 cycles.
`define DELAY_CNT_WIDTH 7

// must hold at least the longest delay.
`define FIFO_DEPTH 128

// cycles the FIFO refuses writes after reset or flush.
`define RST_BUSY_CYCLES 4

`endif

//--- hw/delay_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module delay_ctrl import delay_ctrl_pkg::*; (
  input  wire         CLK,
  input  wire         RESETN,
  input  wire delay_t cur_delay,
  input  wire         flush,
  input  wire         fifo_empty,
  input  wire         fifo_full,
  input  wire         rst_busy,
  output wire         fifo_we,
  output wire         fifo_re,
  output wire         din_ready,
  output logic        out_valid_raw
);

  delay_t cnt;
  delay_t thr;
  logic   read_ready;
  logic   we_q;
  logic   re_q;
  logic   wr_ok;
  logic   at_thr;
  logic   rd_ok;

  // first read goes out cur_delay-2 cycles after the first write.
  // FIFO read and output register add the last two cycles.
  assign thr    = cur_delay - DELAY_MIN;
  assign wr_ok  = !fifo_full && !rst_busy;
  assign at_thr = fifo_we && (cnt >= thr);
  assign rd_ok  = (read_ready || at_thr) && (!fifo_empty || fifo_we);

  assign fifo_we   = we_q && !flush;  // a flush cycle captures nothing.
  assign fifo_re   = re_q && !flush;
  assign din_ready = fifo_we;

  always_ff @(posedge CLK) begin
    if (!RESETN || flush) begin
      cnt        <= '0;
      read_ready <= 1'b0;
    end else begin
      if (fifo_we && (cnt < thr)) begin
        cnt <= cnt + 1'b1;  // saturates at thr.
      end
      if (at_thr) begin
        read_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN || flush) begin
      we_q          <= 1'b0;
      re_q          <= 1'b0;
      out_valid_raw <= 1'b0;
    end else begin
      we_q          <= wr_ok;
      re_q          <= rd_ok;
      out_valid_raw <= fifo_re;  // matches FIFO read latency.
    end
  end

  a_read_has_data: assert property (@(posedge CLK) disable iff (!RESETN)
    fifo_re |-> !fifo_empty)
    else $error("delay_ctrl: read issued with no data in the FIFO");

endmodule

`default_nettype wire

//--- hw/delay_ctrl_pkg.sv
`default_nettype none

`include "delay_consts.svh"

package delay_ctrl_pkg;

  typedef logic [`DELAY_CNT_WIDTH-1:0] delay_t;  // delay in clock cycles.

  // shortest legal delay, covering FIFO read latency plus the output register.
  localparam delay_t DELAY_MIN = 3;

  typedef enum logic [1:0] {
    RUN,        // line streaming with the active delay.
    FLUSH,      // one cycle, restarts the line.
    WAIT_BUSY   // FIFO still in its busy window.
  } cfg_state_t;

endpackage

`default_nettype wire

//--- hw/delay_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "delay_consts.svh"

module delay_fifo #(
  parameter type payload_t = logic [`SAMPLE_WIDTH-1:0],
  parameter int  DEPTH     = `FIFO_DEPTH
) (
  input  wire           CLK,
  input  wire           RESETN,
  input  wire           flush,
  input  wire           we,
  input  wire payload_t wdata,
  input  wire           re,
  output payload_t      rdata,
  output wire           empty,
  output wire           full,
  output wire           rst_busy
);

  localparam int PTR_W  = $clog2(DEPTH);
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int BUSY_W = $clog2(`RST_BUSY_CYCLES + 1);

  payload_t          mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [BUSY_W-1:0] busy_cnt;
  logic              do_wr;
  logic              do_rd;

  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(DEPTH));
  assign rst_busy = (busy_cnt != '0);

  assign do_wr = we && !full && !rst_busy && !flush;
  assign do_rd = re && !empty && !flush;  // flush wins over a read.

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      busy_cnt <= BUSY_W'(`RST_BUSY_CYCLES);
    end else if (flush) begin
      busy_cnt <= BUSY_W'(`RST_BUSY_CYCLES);
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= wdata;
    end
    if (do_rd) begin
      rdata <= mem[rd_ptr];  // data shows one cycle after re.
    end
  end

  a_no_write_full: assert property (@(posedge CLK) disable iff (!RESETN) we |-> !full)
    else $error("delay_fifo: write while full");

  a_no_read_empty: assert property (@(posedge CLK) disable iff (!RESETN) re |-> !empty)
    else $error("delay_fifo: read while empty");

endmodule

`default_nettype wire

//--- hw/delay_line_top.sv
`default_nettype none
`timescale 1ns/1ps

module delay_line_top import sample_pkg::*, delay_ctrl_pkg::*; (
  input  wire          CLK,
  input  wire          RESETN,
  input  wire delay_t  delay,
  input  wire          delay_load,
  input  wire sample_t din,
  output wire          din_ready,
  output sample_t      dout,
  output logic         dout_valid,
  output logic         underrun
);

  delay_t  cur_delay;
  logic    flush;
  logic    fifo_we;
  logic    fifo_re;
  logic    out_valid_raw;
  sample_t fifo_dout;
  logic    fifo_empty;
  logic    fifo_full;
  logic    rst_busy;

  delay_config i_delay_config (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .delay      (delay),
    .delay_load (delay_load),
    .cur_delay  (cur_delay),
    .flush      (flush)
  );

  delay_ctrl i_delay_ctrl (
    .CLK           (CLK),
    .RESETN        (RESETN),
    .cur_delay     (cur_delay),
    .flush         (flush),
    .fifo_empty    (fifo_empty),
    .fifo_full     (fifo_full),
    .rst_busy      (rst_busy),
    .fifo_we       (fifo_we),
    .fifo_re       (fifo_re),
    .din_ready     (din_ready),
    .out_valid_raw (out_valid_raw)
  );

  delay_fifo #(
    .payload_t (sample_t)
  ) i_delay_fifo (
    .CLK      (CLK),
    .RESETN   (RESETN),
    .flush    (flush),
    .we       (fifo_we),
    .wdata    (din),
    .re       (fifo_re),
    .rdata    (fifo_dout),
    .empty    (fifo_empty),
    .full     (fifo_full),
    .rst_busy (rst_busy)
  );

  delay_out i_delay_out (
    .CLK           (CLK),
    .RESETN        (RESETN),
    .flush         (flush),
    .rdata         (fifo_dout),
    .out_valid_raw (out_valid_raw),
    .dout          (dout),
    .dout_valid    (dout_valid),
    .underrun      (underrun)
  );

endmodule

`default_nettype wire

//--- hw/delay_out.sv
`default_nettype none
`timescale 1ns/1ps

module delay_out import sample_pkg::*; (
  input  wire          CLK,
  input  wire          RESETN,
  input  wire          flush,
  input  wire sample_t rdata,
  input  wire          out_valid_raw,
  output sample_t      dout,
  output logic         dout_valid,
  output logic         underrun
);

  logic seen_valid;

  always_ff @(posedge CLK) begin
    if (out_valid_raw) begin
      dout <= rdata;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN || flush) begin
      dout_valid <= 1'b0;  // drops samples still in flight.
      seen_valid <= 1'b0;
      underrun   <= 1'b0;
    end else begin
      dout_valid <= out_valid_raw;
      if (out_valid_raw) begin
        seen_valid <= 1'b1;
      end
      if (seen_valid && !out_valid_raw) begin
        underrun <= 1'b1;  // sticky until the next flush.
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/sample_pkg.sv
`default_nettype none

`include "delay_consts.svh"

package sample_pkg;

  typedef logic [`SAMPLE_WIDTH-1:0] sample_t;  // one stream word.

endpackage

`default_nettype wire

//--- tb.f
+incdir+hw
hw/sample_pkg.sv
hw/delay_ctrl_pkg.sv
hw/delay_fifo.sv
hw/delay_config.sv
hw/delay_ctrl.sv
hw/delay_out.sv
hw/delay_line_top.sv
test/tb_delay_line.sv

//--- test/tb_delay_line.sv
`default_nettype none
`timescale 1ns/1ps

`include "delay_consts.svh"

module tb_delay_line import sample_pkg::*, delay_ctrl_pkg::*; ();

  localparam int LEN_RESET  = 8 + `RST_BUSY_CYCLES + 16;
  localparam int LEN_STREAM = 200 + 10 + 32;
  localparam int LEN_SAME   = 40 + 10;
  localparam int LEN_D40    = 200 + 40 + 48;
  localparam int LEN_D3     = 300 + 3 + 48;
  localparam int LEN_D127   = 300 + 127 + 48;
  localparam int LEN_CLEAR  = 50 + 10 + 48;
  localparam int WATCHDOG_CYCLES = LEN_RESET + LEN_STREAM + LEN_SAME + LEN_D40
                                 + LEN_D3 + LEN_D127 + LEN_CLEAR + 200;

  logic    CLK;
  logic    RESETN;
  delay_t  delay;
  logic    delay_load;
  sample_t din;
  logic    din_ready;
  sample_t dout;
  logic    dout_valid;
  logic    underrun;

  integer      seed;
  logic [31:0] rnd;
  logic [9:0]  stream_cnt;
  int          cyc;
  int          out_cnt;
  int          err_cnt;
  int          chk_cnt;
  logic        mon_en;
  logic        flush_due;
  delay_t      model_delay;
  delay_t      next_delay;
  sample_t     exp_data_q[$];
  int          cap_cyc_q[$];
  delay_t      exp_lat_q[$];
  sample_t     got_data;
  int          got_cap;
  delay_t      got_lat;

  delay_line_top i_delay_line_top (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .delay      (delay),
    .delay_load (delay_load),
    .din        (din),
    .din_ready  (din_ready),
    .dout       (dout),
    .dout_valid (dout_valid),
    .underrun   (underrun)
  );

  always #5 CLK = ~CLK;

  always @(posedge CLK) begin
    cyc <= cyc + 1;
  end

  // counter in the low bits, noise above it.
  always @(posedge CLK) begin
    #1;
    rnd = $random(seed);
    din <= {rnd[`SAMPLE_WIDTH-1:10], stream_cnt};
    stream_cnt <= stream_cnt + 10'd1;
  end

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    chk_cnt++;
    if (act != exp) begin
      err_cnt++;
      $display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  // reference model of the line, sampled mid-cycle.
  always @(negedge CLK) begin
    if (mon_en) begin
      check_flag("underrun", 1'b0, underrun);
      if (dout_valid) begin
        if (exp_data_q.size() == 0) begin
          err_cnt++;
          $display("error at %0t: dout_valid high with no sample due", $time);
        end else begin
          got_data = exp_data_q.pop_front();
          got_cap  = cap_cyc_q.pop_front();
          got_lat  = exp_lat_q.pop_front();
          check_sample("dout", got_data, dout);
          check_latency("dout latency", int'(got_lat), cyc - got_cap);
        end
        out_cnt++;
      end else if (cap_cyc_q.size() != 0 && cap_cyc_q[0] + int'(exp_lat_q[0]) <= cyc) begin
        err_cnt++;
        $display("error at %0t: sample %h did not come out on time", $time, exp_data_q[0]);
        got_data = exp_data_q.pop_front();
        got_cap  = cap_cyc_q.pop_front();
        got_lat  = exp_lat_q.pop_front();
      end
      if (flush_due) begin
        check_flag("din_ready", 1'b0, din_ready);  // flush cycle captures nothing.
        exp_data_q.delete();
        cap_cyc_q.delete();
        exp_lat_q.delete();
        model_delay = next_delay;
        flush_due   = 1'b0;
      end else if (din_ready) begin
        exp_data_q.push_back(din);
        cap_cyc_q.push_back(cyc);
        exp_lat_q.push_back(model_delay);
      end
      if (delay_load && (delay != model_delay)) begin
        next_delay = delay;
        flush_due  = 1'b1;  // flush shows in the next cycle.
      end
    end
  end

  task automatic load_delay(input delay_t value);
    @(posedge CLK);
    #1;
    delay      = value;
    delay_load = 1'b1;
    @(posedge CLK);
    #1;
    delay_load = 1'b0;
  endtask

  task automatic wait_outputs(input int n, input int limit);
    int target;
    int waited;
    target = out_cnt + n;
    waited = 0;
    while (out_cnt < target && waited < limit) begin
      @(posedge CLK);
      waited++;
    end
    if (out_cnt < target) begin
      err_cnt++;
      $display("error at %0t: only %0d of %0d samples came out within %0d cycles",
               $time, n - (target - out_cnt), n, limit);
    end
  endtask

  task automatic test_reset_ready();
    int waited;
    RESETN = 1'b0;
    repeat (8) @(posedge CLK);
    #1;
    RESETN = 1'b1;
    mon_en = 1'b1;
    @(negedge CLK);
    check_flag("din_ready", 1'b0, din_ready);
    check_flag("dout_valid", 1'b0, dout_valid);
    check_flag("underrun", 1'b0, underrun);
    waited = 0;
    while (!din_ready && waited < `RST_BUSY_CYCLES + 8) begin
      @(negedge CLK);
      waited++;
    end
    if (!din_ready) begin
      err_cnt++;
      $display("error at %0t: din_ready never rose after reset", $time);
    end else if (waited <= `RST_BUSY_CYCLES) begin
      err_cnt++;
      $display("error at %0t: din_ready rose inside the reset-busy window", $time);
    end
  endtask

  task automatic test_stream_fixed();
    wait_outputs(200, 200 + 10 + 24);
  endtask

  task automatic test_same_load();
    load_delay(model_delay);
    repeat (40) begin
      @(negedge CLK);
      check_flag("dout_valid", 1'b1, dout_valid);
    end
  endtask

  task automatic test_delay_change(input delay_t value, input int n);
    load_delay(value);
    @(posedge CLK);
    @(negedge CLK);
    check_flag("dout_valid", 1'b0, dout_valid);  // in-flight samples are gone.
    check_flag("din_ready", 1'b0, din_ready);
    wait_outputs(n, n + int'(value) + `RST_BUSY_CYCLES + 24);
  endtask

  task automatic test_flush_clears_underrun();
    @(posedge CLK);
    #1;
    mon_en = 1'b0;  // model is off while the gap is forced.
    force i_delay_line_top.out_valid_raw = 1'b0;  // a missing read.
    @(posedge CLK);
    #1;
    release i_delay_line_top.out_valid_raw;
    @(negedge CLK);
    check_flag("underrun", 1'b1, underrun);
    exp_data_q.delete();
    cap_cyc_q.delete();
    exp_lat_q.delete();
    model_delay = 10;
    load_delay(10);
    @(posedge CLK);
    #1;
    mon_en = 1'b1;
    repeat (3) begin
      @(negedge CLK);
      check_flag("underrun", 1'b0, underrun);
    end
    wait_outputs(50, 50 + 10 + `RST_BUSY_CYCLES + 24);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout at %0t: tests did not finish, %0d errors in %0d checks so far",
             $time, err_cnt, chk_cnt);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    CLK         = 1'b0;
    RESETN      = 1'b0;
    delay       = 10;  // taken as the line delay during reset.
    delay_load  = 1'b0;
    din         = '0;
    seed        = 32'h686;
    stream_cnt  = '0;
    cyc         = 0;
    out_cnt     = 0;
    err_cnt     = 0;
    chk_cnt     = 0;
    mon_en      = 1'b0;
    flush_due   = 1'b0;
    model_delay = 10;
    next_delay  = 10;
    test_reset_ready();
    test_stream_fixed();
    test_same_load();
    test_delay_change(40, 200);
    test_delay_change(3, 300);
    test_delay_change(127, 300);
    test_flush_clears_underrun();
    $display("%0d errors in %0d checks, %0d samples out", err_cnt, chk_cnt, out_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
